// ==== common/decim_pkg.sv ====
// shared types for the stream decimator
// the interval width caps the drop interval at 15 cycles
`default_nettype none

package decim_pkg;

  // ========================================
  // widths
  // ========================================
  localparam int SAMPLE_BITS   = 16;
  localparam int INTERVAL_BITS = 4;
  localparam int SEQ_BITS      = 8;

  // ========================================
  // payload types
  // ========================================
  typedef logic [SAMPLE_BITS-1:0] sample_t;
  typedef logic [SEQ_BITS-1:0]    seq_t;     // wraps around

  // payload at the output stream
  typedef struct packed {
    sample_t sample;
    seq_t    seq;
  } kept_sample_t;

  typedef logic [INTERVAL_BITS-1:0] interval_t;  // drop interval in cycles

  // send passes the next sample, drop discards input
  typedef enum logic {
    send = 1'b0,
    drop = 1'b1
  } drop_state_t;

endpackage

`default_nettype wire

// ==== common/drop_cfg_if.sv ====
// interval and bypass settings shared by the config bank and the drop FSM
// interval_msg/interval_val come straight from the top-level ports
`default_nettype none
`timescale 1ns/1ps

interface drop_cfg_if import decim_pkg::*; ();

  interval_t interval;      // active drop interval
  logic      bypass;        // pass every sample when high
  logic      load_open;     // fsm is in send, interval may change

  interval_t interval_msg;  // requested interval
  logic      interval_val;
  logic      interval_rdy;

  modport regs (
    input  load_open,
    input  interval_msg,
    input  interval_val,
    output interval,
    output bypass,
    output interval_rdy
  );

  modport fsm (
    input  interval,
    input  bypass,
    output load_open
  );

endinterface

`default_nettype wire

// ==== source/stream_queue.sv ====
// two-entry val/rdy queue, all outputs come from registers
// in_rdy only looks at the fill level, so it never depends on out_rdy
`default_nettype none
`timescale 1ns/1ps

module stream_queue #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     reset,

  input  payload_t in_msg,
  input  logic     in_val,
  output logic     in_rdy,

  output payload_t out_msg,
  output logic     out_val,
  input  logic     out_rdy
);

  payload_t   slots [2];
  logic       head;        // slot read next
  logic [1:0] count;       // entries held, 0 to 2
  logic       push;
  logic       pop;
  logic       tail;        // slot written next

  assign in_rdy  = (count != 2'd2);
  assign out_val = (count != 2'd0);
  assign out_msg = slots[head];

  assign push = in_val & in_rdy;
  assign pop  = out_val & out_rdy;
  assign tail = head ^ count[0];   // head + count mod 2

  // payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      slots[tail] <= in_msg;
    end
  end

  // ========================================
  // pointer and fill level
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      head  <= 1'b0;
      count <= 2'd0;
    end else begin
      if (pop) begin
        head <= ~head;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;      // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== drop_unit/drop_interval_counter.sv ====
// cycle counter for the drop phase
// intervals below 2 end the drop phase after a single cycle
`default_nettype none
`timescale 1ns/1ps

module drop_interval_counter import decim_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  input  logic      counting,   // fsm is in drop
  input  interval_t interval,
  output logic      last        // final drop cycle
);

  localparam interval_t two = interval_t'(2);

  interval_t count;
  logic      short_interval;

  assign short_interval = (interval < two);

  // drop lasts interval - 1 cycles, count starts at 0
  assign last = short_interval || (count == interval - two);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (!counting) begin
      count <= '0;                      // held clear in send
    end else begin
      count <= count + interval_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== drop_unit/drop_cfg_regs.sv ====
// configuration bank for the drop interval and the bypass switch
// interval accepted only while the fsm sits in send, bypass any time
`default_nettype none
`timescale 1ns/1ps

module drop_cfg_regs import decim_pkg::*; #(
  parameter int RESET_INTERVAL = 4
) (
  input  logic      clk,
  input  logic      reset,

  drop_cfg_if.regs  cfg,

  input  logic      bypass,       // new bypass value
  input  logic      bypass_val    // load strobe for bypass
);

  logic interval_xfer;

  // ready tracks the send state directly
  assign cfg.interval_rdy = cfg.load_open;
  assign interval_xfer    = cfg.interval_val & cfg.interval_rdy;

  // ========================================
  // interval register
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.interval <= interval_t'(RESET_INTERVAL);
    end else if (interval_xfer) begin
      cfg.interval <= cfg.interval_msg;
    end
  end

  // ========================================
  // bypass register
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.bypass <= 1'b0;          // decimating after reset
    end else if (bypass_val) begin
      cfg.bypass <= bypass;
    end
  end

endmodule

`default_nettype wire

// ==== drop_unit/drop_fsm.sv ====
// send/drop control with the pass-or-discard path and the sequence tagger
// send path is combinational, so it adds no cycles between the queues
`default_nettype none
`timescale 1ns/1ps

module drop_fsm import decim_pkg::*; (
  input  logic         clk,
  input  logic         reset,

  drop_cfg_if.fsm      cfg,

  input  sample_t      in_msg,
  input  logic         in_val,
  output logic         in_rdy,

  output kept_sample_t out_msg,
  output logic         out_val,
  input  logic         out_rdy,

  output logic         counting,   // high in drop
  input  logic         last        // final drop cycle
);

  drop_state_t state;
  drop_state_t next_state;
  seq_t        seq_num;
  logic        out_xfer;

  assign out_xfer      = out_val & out_rdy;
  assign counting      = (state == drop);
  assign cfg.load_open = (state == send);

  // ========================================
  // data path
  // ========================================
  always_comb begin
    in_rdy  = 1'b1;             // drop swallows everything
    out_val = 1'b0;
    out_msg = '0;
    if (state == send) begin
      in_rdy         = out_rdy;
      out_val        = in_val;
      out_msg.sample = in_msg;
      out_msg.seq    = seq_num;
    end
  end

  // next state
  always_comb begin
    next_state = state;
    case (state)
      send: if (out_xfer && !cfg.bypass) next_state = drop;
      drop: if (last || cfg.bypass) next_state = send;
      default: next_state = send;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= send;
      seq_num <= '0;
    end else begin
      state <= next_state;
      if (out_xfer) begin
        seq_num <= seq_num + seq_t'(1);  // one tag per kept sample
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/sample_decimator.sv ====
// stream decimator top, input queue -> drop unit -> output queue
// input to out_val is 2 cycles in send with empty queues
`default_nettype none
`timescale 1ns/1ps

module sample_decimator import decim_pkg::*; #(
  parameter int RESET_INTERVAL = 4
) (
  input  logic         clk,
  input  logic         reset,

  input  sample_t      in_msg,
  input  logic         in_val,
  output logic         in_rdy,

  output kept_sample_t out_msg,
  output logic         out_val,
  input  logic         out_rdy,

  input  interval_t    cfg_interval_msg,
  input  logic         cfg_interval_val,
  output logic         cfg_interval_rdy,

  input  logic         cfg_bypass,
  input  logic         cfg_bypass_val
);

  sample_t      q_in_msg;      // input queue to fsm
  logic         q_in_val;
  logic         q_in_rdy;
  kept_sample_t fsm_out_msg;   // fsm to output queue
  logic         fsm_out_val;
  logic         fsm_out_rdy;
  logic         counting;
  logic         last;

  drop_cfg_if cfg ();

  assign cfg.interval_msg = cfg_interval_msg;
  assign cfg.interval_val = cfg_interval_val;
  assign cfg_interval_rdy = cfg.interval_rdy;

  stream_queue #(.payload_t(sample_t)) i_in_queue (
    .clk(clk), .reset(reset),
    .in_msg(in_msg), .in_val(in_val), .in_rdy(in_rdy),
    .out_msg(q_in_msg), .out_val(q_in_val), .out_rdy(q_in_rdy)
  );

  drop_fsm i_drop_fsm (
    .clk(clk), .reset(reset), .cfg(cfg.fsm),
    .in_msg(q_in_msg), .in_val(q_in_val), .in_rdy(q_in_rdy),
    .out_msg(fsm_out_msg), .out_val(fsm_out_val), .out_rdy(fsm_out_rdy),
    .counting(counting), .last(last)
  );

  drop_interval_counter i_drop_counter (
    .clk(clk), .reset(reset),
    .counting(counting), .interval(cfg.interval), .last(last)
  );

  drop_cfg_regs #(.RESET_INTERVAL(RESET_INTERVAL)) i_drop_cfg (
    .clk(clk), .reset(reset), .cfg(cfg.regs),
    .bypass(cfg_bypass), .bypass_val(cfg_bypass_val)
  );

  stream_queue #(.payload_t(kept_sample_t)) i_out_queue (
    .clk(clk), .reset(reset),
    .in_msg(fsm_out_msg), .in_val(fsm_out_val), .in_rdy(fsm_out_rdy),
    .out_msg(out_msg), .out_val(out_val), .out_rdy(out_rdy)
  );

endmodule

`default_nettype wire

// ==== bench/sample_decimator_chk.sv ====
// concurrent checks bound into the decimator top
// kept_val/kept_rdy are the fsm to output queue handshake inside the top
`default_nettype none
`timescale 1ns/1ps

module sample_decimator_chk import decim_pkg::*; #(
  parameter int RESET_INTERVAL = 4
) (
  input logic         clk,
  input logic         reset,
  input kept_sample_t out_msg,
  input logic         out_val,
  input logic         out_rdy,
  input interval_t    cfg_interval_msg,
  input logic         cfg_interval_val,
  input logic         cfg_interval_rdy,
  input logic         cfg_bypass,
  input logic         cfg_bypass_val,
  input logic         kept_val,   // fsm output handshake
  input logic         kept_rdy
);

  logic      bypass_q;       // mirror of the bypass register
  interval_t interval_q;     // mirror of the interval register
  interval_t interval_now;   // interval a drop phase starting now uses
  logic      interval_xfer;
  logic      kept_xfer;
  interval_t lock_left;      // drop cycles still ahead

  assign interval_xfer = cfg_interval_val && cfg_interval_rdy;
  assign kept_xfer     = kept_val && kept_rdy && !bypass_q;
  assign interval_now  = interval_xfer ? cfg_interval_msg : interval_q;

  // ========================================
  // settings mirror and drop window
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      bypass_q   <= 1'b0;
      interval_q <= interval_t'(RESET_INTERVAL);
      lock_left  <= '0;
    end else begin
      if (cfg_bypass_val) begin
        bypass_q <= cfg_bypass;
      end
      if (interval_xfer) begin
        interval_q <= cfg_interval_msg;
      end
      if (kept_xfer) begin
        // drop lasts interval - 1 cycles and never less than one
        lock_left <= (interval_now < interval_t'(2)) ? interval_t'(1)
                                                     : interval_now - interval_t'(1);
      end else if (bypass_q) begin
        lock_left <= '0;             // bypass ends a drop phase at once
      end else if (lock_left != '0) begin
        lock_left <= lock_left - interval_t'(1);
      end
    end
  end

  // stalled output keeps its item
  hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(out_msg))
    else $error("out_msg or out_val changed while out_rdy was low");

  // interval loads stay closed for the whole drop phase
  interval_locked: assert property (@(posedge clk) disable iff (reset)
    lock_left != '0 |-> !cfg_interval_rdy)
    else $error("cfg_interval_rdy high before the drop interval elapsed");

  quiet_in_reset: assert property (@(posedge clk) reset |=> !out_val)
    else $error("out_val high during reset");

endmodule

`default_nettype wire

// ==== bench/sample_decimator_tb.sv ====
// stream decimator testbench
// input ramp makes every sample value unique
// stalls come from $random with a fixed seed
`default_nettype none
`timescale 1ns/1ps

module sample_decimator_tb import decim_pkg::*; ();

  localparam int test_len        = 120;               // flow cycles per test
  localparam int watchdog_cycles = 5 * test_len + 200;

  logic         clk = 1'b0;
  logic         reset = 1'b1;
  sample_t      in_msg = '0;
  logic         in_val = 1'b0;
  logic         in_rdy;
  kept_sample_t out_msg;
  logic         out_val;
  logic         out_rdy = 1'b1;
  interval_t    cfg_interval_msg = '0;
  logic         cfg_interval_val = 1'b0;
  logic         cfg_interval_rdy;
  logic         cfg_bypass = 1'b0;
  logic         cfg_bypass_val = 1'b0;

  logic        src_on = 1'b0;        // source offers samples
  logic        stall_mode = 1'b0;    // random in_val and out_rdy
  sample_t     expect_step = '0;     // 0 skips the spacing check
  int          phase = 0;
  int          prev_phase = -1;
  sample_t     prev_sample = '0;
  seq_t        exp_seq = '0;
  sample_t     ramp = '0;
  sample_t     sent_q [$];           // sent, not yet matched
  int          errors = 0;
  int          kept_count = 0;
  int          err_mark = 0;
  int          kept_mark = 0;
  int          tests_failed = 0;
  integer      seed = 85024;
  logic [31:0] rnd;

  sample_decimator #(.RESET_INTERVAL(4)) i_sample_decimator (.*);

  bind sample_decimator sample_decimator_chk #(.RESET_INTERVAL(RESET_INTERVAL)) i_chk (
    .clk(clk), .reset(reset), .out_msg(out_msg), .out_val(out_val), .out_rdy(out_rdy),
    .cfg_interval_msg(cfg_interval_msg), .cfg_interval_val(cfg_interval_val),
    .cfg_interval_rdy(cfg_interval_rdy), .cfg_bypass(cfg_bypass),
    .cfg_bypass_val(cfg_bypass_val), .kept_val(fsm_out_val), .kept_rdy(fsm_out_rdy)
  );

  always #20 clk = ~clk;

  // ========================================
  // source, sink and sent-sample model
  // ========================================
  always @(posedge clk) begin
    rnd = $random(seed);
    if (reset) begin
      in_val <= 1'b0;
    end else begin
      if (in_val && in_rdy) begin
        sent_q.push_back(in_msg);
        ramp = ramp + sample_t'(1);
      end
      if (!in_val || in_rdy) begin   // free to change once transferred
        in_val <= src_on && (!stall_mode || rnd[0]);
        in_msg <= ramp;
      end
      out_rdy <= !stall_mode || rnd[1];
    end
  end

  task automatic value_error(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    $display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, act);
    errors = errors + 1;
  endtask

  // ========================================
  // output monitor
  // ========================================
  always @(posedge clk) begin
    if (reset) begin
      sent_q.delete();              // in-flight samples are lost
      exp_seq    <= '0;
      prev_phase <= -1;
    end else if (out_val && out_rdy) begin
      kept_count = kept_count + 1;
      assert (out_msg.seq == exp_seq)
        else value_error("out_msg.seq", 32'(exp_seq), 32'(out_msg.seq));
      exp_seq <= exp_seq + seq_t'(1);
      while (sent_q.size() > 0 && sent_q[0] != out_msg.sample) begin
        void'(sent_q.pop_front());  // discarded by the decimator
      end
      assert (sent_q.size() > 0) else begin
        $display("[ERROR] out_msg.sample 0x%0h was never sent or came out of order",
                 out_msg.sample);
        errors = errors + 1;
      end
      if (sent_q.size() > 0) begin
        void'(sent_q.pop_front());
      end
      if (prev_phase == phase && expect_step != '0) begin
        assert (sample_t'(out_msg.sample - prev_sample) == expect_step)
          else value_error("out_msg.sample step", 32'(expect_step),
                           32'(sample_t'(out_msg.sample - prev_sample)));
      end
      prev_sample <= out_msg.sample;
      prev_phase  <= phase;
    end
  end

  // opens a flow segment whose kept values lie step apart
  task automatic start_flow(input int step, input logic stall);
    @(posedge clk);
    phase       <= phase + 1;
    expect_step <= sample_t'(step);
    stall_mode  <= stall;
    src_on      <= 1'b1;
  endtask

  // stop the source and wait until both queues are empty in send
  task automatic drain();
    int idle;
    idle = 0;
    src_on     <= 1'b0;
    stall_mode <= 1'b0;
    while (idle < 4) begin
      @(posedge clk);
      idle = (!in_val && !out_val && cfg_interval_rdy) ? idle + 1 : 0;
    end
  endtask

  task automatic end_test(input int num, input int min_out);
    int outs;
    drain();
    outs = kept_count - kept_mark;
    if (errors != err_mark || outs < min_out) begin
      tests_failed = tests_failed + 1;
      $display("test %0d FAIL: %0d errors, %0d outputs where at least %0d were needed",
               num, errors - err_mark, outs, min_out);
    end else begin
      $display("test %0d ok: %0d outputs", num, outs);
    end
    err_mark  = errors;
    kept_mark = kept_count;
  endtask

  task automatic set_bypass(input logic value);
    @(posedge clk);
    cfg_bypass     <= value;
    cfg_bypass_val <= 1'b1;
    @(posedge clk);
    cfg_bypass_val <= 1'b0;
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    start_flow(4, 1'b0);                      // reset interval
    repeat (test_len) @(posedge clk);
    end_test(1, 10);
    @(posedge clk);
    cfg_interval_msg <= interval_t'(6);
    cfg_interval_val <= 1'b1;
    do begin
      @(posedge clk);
    end while (!cfg_interval_rdy);
    cfg_interval_val <= 1'b0;
    start_flow(6, 1'b0);
    repeat (test_len) @(posedge clk);
    end_test(2, 8);
    set_bypass(1'b1);
    start_flow(1, 1'b1);                      // every sample passes under stalls
    repeat (test_len / 2) @(posedge clk);
    drain();
    set_bypass(1'b0);
    start_flow(6, 1'b0);
    repeat (test_len / 2) @(posedge clk);
    end_test(3, 20);
    start_flow(0, 1'b1);                      // stalls on both sides
    repeat (test_len) @(posedge clk);
    end_test(4, 5);
    start_flow(6, 1'b0);
    repeat (test_len / 3) @(posedge clk);
    reset <= 1'b1;                            // mid-traffic
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    start_flow(4, 1'b0);                      // interval back to its reset value
    repeat (2 * test_len / 3) @(posedge clk);
    end_test(5, 10);
    $display("%0d tests passed, %0d failed, %0d errors", 5 - tests_failed, tests_failed,
             errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, a test never finished", watchdog_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sample_decimator.f ====
common/decim_pkg.sv
common/drop_cfg_if.sv
source/stream_queue.sv
drop_unit/drop_interval_counter.sv
drop_unit/drop_cfg_regs.sv
drop_unit/drop_fsm.sv
source/sample_decimator.sv
bench/sample_decimator_chk.sv
bench/sample_decimator_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := sample_decimator_tb
FILELIST  := sample_decimator.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || { echo "simulation stopped early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
